//--- filelist.f
verilog/icache_pkg.sv
verilog/fetch_stage.sv
verilog/icache_array.sv
verilog/mem_tag_table.sv
verilog/prefetch_ctrl.sv
verilog/icache_top.sv
bench/mem_model.sv
bench/icache_tb.sv

//--- bench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

  localparam int NUM_LINES       = 32;
  localparam int ADDR_BITS       = 16;
  localparam int HALF_PERIOD     = 20;
  localparam int RESET_CYCLES    = 2;
  localparam int SEQ_WORDS       = 300;
  localparam int SEQ_MAX_CYCLES  = 3000;
  localparam int REDIRECT_CYCLES = 1200;
  localparam int STALL_CYCLES    = 1000;
  localparam int LOOP_CYCLES     = 1200;
  localparam int DRAIN_CYCLES    = 40;
  localparam int MAX_RETURN_WAIT = 32;
  localparam int WATCHDOG_CYCLES = (RESET_CYCLES + 1 + SEQ_MAX_CYCLES + REDIRECT_CYCLES
                                    + STALL_CYCLES + LOOP_CYCLES + DRAIN_CYCLES) * 5 / 4;
  localparam longint unsigned ADDR_LIMIT = 64'h1 << ADDR_BITS;

  logic        clock;
  logic        reset;
  logic        redirect;
  logic [63:0] redirect_pc;
  logic        stall;
  mem_req_t    mem_req;
  mem_resp_t   mem_resp;
  fetch_out_t  fetch;

  integer              seed = 51;
  logic [63:0]         exp_pc = 64'h0;
  int                  fetch_errors = 0;
  int                  bus_errors = 0;
  int                  fetch_checks = 0;
  int                  bus_checks = 0;
  int                  tests_failed = 0;
  int                  words = 0;
  int                  accepted = 0;
  logic [MEM_TAGS-1:0] outstanding = '0;
  int                  wait_cycles [MEM_TAGS];

  icache_top #(.NUM_LINES(NUM_LINES), .ADDR_BITS(ADDR_BITS)) DUT (
    .i_clock       (clock),
    .i_reset       (reset),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .i_stall       (stall),
    .i_mem_resp    (mem_resp),
    .o_mem_req     (mem_req),
    .o_fetch       (fetch)
  );

  mem_model #(.SEED(51)) u_mem (
    .i_clock    (clock),
    .i_reset    (reset),
    .i_mem_req  (mem_req),
    .o_mem_resp (mem_resp)
  );

  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  // --------------------------------------------------
  // Reference model of the fetch stream
  // --------------------------------------------------

  function automatic logic [63:0] expected_word(input logic [63:0] addr);
    return {~addr[31:0], addr[31:0]};
  endfunction

  function automatic logic [63:0] random_pc();
    integer r;
    r = $random(seed);
    return ($unsigned(r) % ADDR_LIMIT) & ~64'h7;
  endfunction

  function automatic logic one_in(input int n);
    return ($unsigned($random(seed)) % n) == 0;
  endfunction

  // The inputs still hold what was driven one cycle ago, which is what
  // the DUT used to produce the word seen now.
  task automatic check_output();
    if (fetch.valid) begin
      fetch_checks++;
      assert (!stall && !redirect) else begin
        $display("t=%0t a word was delivered in a stalled or redirected cycle", $time);
        fetch_errors++;
      end
      assert (fetch.pc == exp_pc) else begin
        $display("FAILED t=%0t o_fetch.pc got %h expected %h", $time, fetch.pc, exp_pc);
        fetch_errors++;
      end
      assert (fetch.inst == expected_word(exp_pc)) else begin
        $display("FAILED t=%0t o_fetch.inst got %h expected %h", $time, fetch.inst,
                 expected_word(exp_pc));
        fetch_errors++;
      end
      exp_pc = exp_pc + 64'd8;
      words++;
    end
  endtask

  task automatic run_cycle(input logic redir, input logic [63:0] rpc, input logic stl);
    @(negedge clock);
    check_output();
    if (redir) begin
      exp_pc = rpc;
    end
    redirect    = redir;
    redirect_pc = rpc;
    stall       = stl;
  endtask

  task automatic report_test(input string name, input int errs, input int items);
    if (errs == 0) begin
      $display("test %-10s PASS  items=%0d", name, items);
    end else begin
      $display("test %-10s FAIL  items=%0d errors=%0d", name, items, errs);
      tests_failed++;
    end
  endtask

  // --------------------------------------------------
  // Memory bus monitor
  // --------------------------------------------------

  always @(posedge clock) begin
    if (reset) begin
      outstanding = '0;
    end else begin
      for (int t = 1; t < MEM_TAGS; t++) begin
        if (outstanding[t]) begin
          wait_cycles[t]++;
          assert (wait_cycles[t] <= MAX_RETURN_WAIT) else begin
            $display("t=%0t tag %0d was accepted but its data never came back", $time, t);
            bus_errors++;
            outstanding[t] = 1'b0;
          end
        end
      end
      if (mem_req.command == BUS_LOAD) begin
        bus_checks++;
        assert ((mem_req.addr[2:0] == 3'b000) && (mem_req.addr < ADDR_LIMIT)) else begin
          $display("FAILED t=%0t o_mem_req.addr got %h expected aligned below %h", $time,
                   mem_req.addr, ADDR_LIMIT);
          bus_errors++;
        end
      end
      if (mem_resp.tag != 4'h0) begin
        assert (outstanding[mem_resp.tag]) else begin
          $display("t=%0t data returned for tag %0d which is not outstanding", $time,
                   mem_resp.tag);
          bus_errors++;
        end
        outstanding[mem_resp.tag] = 1'b0;
      end
      if (mem_resp.response != 4'h0) begin
        outstanding[mem_resp.response] = 1'b1;
        wait_cycles[mem_resp.response] = 0;
        accepted++;
      end
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    int          mark;
    int          n;
    logic [15:0] loop_base;
    logic [63:0] rpc;
    reset       = 1'b1;
    redirect    = 1'b0;
    redirect_pc = 64'h0;
    stall       = 1'b0;

    mark = fetch_errors;
    repeat (RESET_CYCLES) begin
      @(negedge clock);
      assert (!fetch.valid && (mem_req.command != BUS_LOAD)) else begin
        $display("t=%0t a valid word or a bus load appeared during reset", $time);
        fetch_errors++;
      end
    end
    reset = 1'b0;
    @(negedge clock);
    assert (!fetch.valid) else begin
      $display("FAILED t=%0t o_fetch.valid got 1 expected 0", $time);
      fetch_errors++;
    end
    // One idle cycle follows reset, then the loads start.
    assert (mem_req.command == BUS_LOAD) else begin
      $display("FAILED t=%0t o_mem_req.command got %0d expected %0d", $time,
               mem_req.command, BUS_LOAD);
      fetch_errors++;
    end
    report_test("reset", fetch_errors - mark, RESET_CYCLES);

    // The pc comes out of reset at 0, which the model already holds.
    mark  = fetch_errors;
    words = 0;
    n     = 0;
    while ((words < SEQ_WORDS) && (n < SEQ_MAX_CYCLES)) begin
      run_cycle(1'b0, 64'h0, 1'b0);
      n++;
    end
    assert (words >= SEQ_WORDS) else begin
      $display("sequential fetch delivered only %0d of %0d words", words, SEQ_WORDS);
      fetch_errors++;
    end
    report_test("sequential", fetch_errors - mark, words);

    mark  = fetch_errors;
    words = 0;
    for (n = 0; n < REDIRECT_CYCLES; n++) begin
      run_cycle(one_in(20), random_pc(), 1'b0);
    end
    report_test("redirects", fetch_errors - mark, words);

    // Stalls come in runs, toggling with a chance of one in four.
    mark  = fetch_errors;
    words = 0;
    for (n = 0; n < STALL_CYCLES; n++) begin
      run_cycle(1'b0, 64'h0, one_in(4) ? !stall : stall);
    end
    report_test("stalls", fetch_errors - mark, words);

    mark      = fetch_errors;
    words     = 0;
    loop_base = 16'(random_pc());
    for (n = 0; n < LOOP_CYCLES; n++) begin
      if ((n != 0) && (n % 150 == 0)) begin
        // A step of NUM_LINES words keeps the indices and changes the tags.
        if (one_in(2)) begin
          loop_base = loop_base + 16'(NUM_LINES * 8 * (1 + $unsigned($random(seed)) % 3));
        end else begin
          loop_base = 16'(random_pc());
        end
      end
      rpc = {48'h0, loop_base + 16'(8 * ($unsigned($random(seed)) % 8))};
      run_cycle(one_in(8), rpc, one_in(6));
    end
    report_test("loops", fetch_errors - mark, words);

    repeat (DRAIN_CYCLES) run_cycle(1'b0, 64'h0, 1'b0);
    report_test("bus", bus_errors, accepted);

    $display("tests failed=%0d fetch checks=%0d bus checks=%0d errors=%0d", tests_failed,
             fetch_checks, bus_checks, fetch_errors + bus_errors);
    if ((tests_failed == 0) && (fetch_errors == 0) && (bus_errors == 0)) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- bench/mem_model.sv
`timescale 1ns/1ps

module mem_model import icache_pkg::*; #(
  parameter int SEED        = 1,
  parameter int MIN_LATENCY = 4,
  parameter int MAX_LATENCY = 8
) (
  input  logic      i_clock,
  input  logic      i_reset,
  input  mem_req_t  i_mem_req,
  output mem_resp_t o_mem_resp
);

  logic [MEM_TAGS-1:0] busy;
  int                  countdown [MEM_TAGS];
  logic [63:0]         load_addr [MEM_TAGS];
  integer              seed;

  // Memory contents are a pure function of the address.
  function automatic logic [63:0] word_at(input logic [63:0] addr);
    return {~addr[31:0], addr[31:0]};
  endfunction

  initial begin
    seed       = SEED;
    busy       = '0;
    o_mem_resp = '0;
  end

  // The request is stable between rising edges, so the response is
  // formed at the falling edge and seen by the cache at the next rising one.
  always @(negedge i_clock) begin
    int ret_tag;
    int acc_tag;
    int free_tag;
    ret_tag  = 0;
    acc_tag  = 0;
    free_tag = 0;
    if (i_reset) begin
      busy       = '0;
      o_mem_resp = '0;
    end else begin
      // Only one tag returns per cycle, the lowest one that is due.
      for (int t = MEM_TAGS - 1; t >= 1; t--) begin
        if (busy[t]) begin
          if (countdown[t] > 0) begin
            countdown[t]--;
          end
          if (countdown[t] == 0) begin
            ret_tag = t;
          end
        end
      end
      if ((i_mem_req.command == BUS_LOAD) && (($unsigned($random(seed)) % 4) != 0)) begin
        for (int t = MEM_TAGS - 1; t >= 1; t--) begin
          if (!busy[t]) begin
            free_tag = t;
          end
        end
        if (free_tag != 0) begin
          busy[free_tag]      = 1'b1;
          countdown[free_tag] = MIN_LATENCY
                                + ($unsigned($random(seed)) % (MAX_LATENCY - MIN_LATENCY + 1));
          load_addr[free_tag] = i_mem_req.addr;
          acc_tag             = free_tag;
        end
      end
      if (ret_tag != 0) begin
        busy[ret_tag] = 1'b0;
      end
      o_mem_resp.response = 4'(acc_tag);
      o_mem_resp.tag      = 4'(ret_tag);
      o_mem_resp.data     = (ret_tag != 0) ? word_at(load_addr[ret_tag]) : 64'h0;
    end
  end

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
  parameter int NUM_LINES = 32,
  parameter int ADDR_BITS = 16
) (
  input  logic        i_clock,
  input  logic        i_reset,
  input  logic        i_redirect,
  input  logic [63:0] i_redirect_pc,
  input  logic        i_stall,
  input  mem_resp_t   i_mem_resp,
  output mem_req_t    o_mem_req,
  output fetch_out_t  o_fetch
);

  localparam int IDX_BITS = $clog2(NUM_LINES);
  localparam int TAG_BITS = ADDR_BITS - 3 - IDX_BITS;

  logic [63:0]         fetch_addr;
  logic                running;
  logic                hit;
  logic [63:0]         hit_data;
  logic                tag_match;
  logic                in_window;
  logic [IDX_BITS-1:0] tail_idx;
  logic [TAG_BITS-1:0] tail_tag;
  logic                accept;
  logic [IDX_BITS-1:0] accept_idx;
  logic [TAG_BITS-1:0] accept_tag;
  logic                fill;
  logic [IDX_BITS-1:0] fill_idx;
  logic [TAG_BITS-1:0] fill_tag;

  fetch_stage u_fetch (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_redirect    (i_redirect),
    .i_redirect_pc (i_redirect_pc),
    .i_stall       (i_stall),
    .i_hit         (hit),
    .i_hit_data    (hit_data),
    .o_fetch_addr  (fetch_addr),
    .o_fetch       (o_fetch),
    .o_running     (running)
  );

  icache_array #(.NUM_LINES(NUM_LINES), .ADDR_BITS(ADDR_BITS)) u_array (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_fetch_addr (fetch_addr),
    .i_in_window  (in_window),
    .i_fill       (fill),
    .i_fill_idx   (fill_idx),
    .i_fill_tag   (fill_tag),
    .i_fill_data  (i_mem_resp.data),
    .i_tail_idx   (tail_idx),
    .o_hit        (hit),
    .o_hit_data   (hit_data),
    .o_tag_match  (tag_match),
    .o_tail_tag   (tail_tag)
  );

  mem_tag_table #(.NUM_LINES(NUM_LINES), .ADDR_BITS(ADDR_BITS)) u_table (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_accept     (accept),
    .i_resp_tag   (i_mem_resp.response),
    .i_accept_idx (accept_idx),
    .i_accept_tag (accept_tag),
    .i_ret_tag    (i_mem_resp.tag),
    .o_fill       (fill),
    .o_fill_idx   (fill_idx),
    .o_fill_tag   (fill_tag)
  );

  prefetch_ctrl #(.NUM_LINES(NUM_LINES), .ADDR_BITS(ADDR_BITS)) u_prefetch (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_running    (running),
    .i_fetch_addr (fetch_addr),
    .i_tag_match  (tag_match),
    .i_tail_tag   (tail_tag),
    .i_resp_tag   (i_mem_resp.response),
    .o_mem_req    (o_mem_req),
    .o_in_window  (in_window),
    .o_tail_idx   (tail_idx),
    .o_accept     (accept),
    .o_accept_idx (accept_idx),
    .o_accept_tag (accept_tag)
  );

endmodule

//--- verilog/prefetch_ctrl.sv
`timescale 1ns/1ps

module prefetch_ctrl import icache_pkg::*; #(
  parameter  int NUM_LINES = 32,
  parameter  int ADDR_BITS = 16,
  localparam int IDX_BITS  = $clog2(NUM_LINES),
  localparam int TAG_BITS  = ADDR_BITS - 3 - IDX_BITS
) (
  input  logic                i_clock,
  input  logic                i_reset,
  input  logic                i_running,
  input  logic [63:0]         i_fetch_addr,
  input  logic                i_tag_match,
  input  logic [TAG_BITS-1:0] i_tail_tag,
  input  logic [3:0]          i_resp_tag,
  output mem_req_t            o_mem_req,
  output logic                o_in_window,
  output logic [IDX_BITS-1:0] o_tail_idx,
  output logic                o_accept,
  output logic [IDX_BITS-1:0] o_accept_idx,
  output logic [TAG_BITS-1:0] o_accept_tag
);

  logic [IDX_BITS-1:0] head;
  logic [IDX_BITS-1:0] tail;
  logic [IDX_BITS-1:0] next_head;
  logic [IDX_BITS-1:0] next_tail;
  logic [IDX_BITS-1:0] fetch_idx;
  logic [TAG_BITS-1:0] fetch_tag;
  logic [IDX_BITS-1:0] head_dist;
  logic [IDX_BITS-1:0] tail_dist;
  logic [IDX_BITS-1:0] tail_step;
  logic                window_hit;

  assign fetch_idx = i_fetch_addr[IDX_BITS+2:3];
  assign fetch_tag = i_fetch_addr[ADDR_BITS-1:IDX_BITS+3];

  // Distances are taken modulo the line count so the window may wrap.
  assign head_dist   = fetch_idx - head;
  assign tail_dist   = tail - head;
  assign o_in_window = (head_dist <= tail_dist);
  assign window_hit  = o_in_window && i_tag_match;
  assign tail_step   = tail + 1'b1;

  assign o_accept   = i_running && (i_resp_tag != 4'h0);
  assign o_tail_idx = tail;

  // --------------------------------------------------
  // Request choice
  // --------------------------------------------------

  always_comb begin
    o_mem_req.command = i_running ? BUS_LOAD : BUS_NONE;
    if (window_hit) begin
      o_mem_req.addr = {{(64-ADDR_BITS){1'b0}}, i_tail_tag, tail, 3'b000};
      o_accept_idx   = tail;
      o_accept_tag   = i_tail_tag;
    end else begin
      o_mem_req.addr = {{(64-ADDR_BITS){1'b0}}, fetch_tag, fetch_idx, 3'b000};
      o_accept_idx   = fetch_idx;
      o_accept_tag   = fetch_tag;
    end
  end

  // --------------------------------------------------
  // Window update
  // --------------------------------------------------

  always_comb begin
    next_head = head;
    next_tail = tail;
    if (i_running) begin
      if (window_hit) begin
        if (o_accept && (tail_step != head)) begin
          next_tail = tail_step;
        end
      end else begin
        // A miss restarts the window at the fetch line.
        next_head = fetch_idx;
        next_tail = o_accept ? fetch_idx + 1'b1 : fetch_idx;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      head <= next_head;
      tail <= next_tail;
    end
  end

  // A prefetch takes its tag from the array, so the load address is only as
  // known as the line it names.
  a_load_addr_known: assert property (
    @(posedge i_clock) disable iff (i_reset)
    (o_mem_req.command == BUS_LOAD) |-> !$isunknown(o_mem_req.addr)
  ) else $error("prefetch_ctrl: load issued with an unknown address");

endmodule

//--- verilog/mem_tag_table.sv
`timescale 1ns/1ps

module mem_tag_table import icache_pkg::*; #(
  parameter  int NUM_LINES = 32,
  parameter  int ADDR_BITS = 16,
  localparam int IDX_BITS  = $clog2(NUM_LINES),
  localparam int TAG_BITS  = ADDR_BITS - 3 - IDX_BITS
) (
  input  logic                i_clock,
  input  logic                i_reset,
  input  logic                i_accept,
  input  logic [3:0]          i_resp_tag,
  input  logic [IDX_BITS-1:0] i_accept_idx,
  input  logic [TAG_BITS-1:0] i_accept_tag,
  input  logic [3:0]          i_ret_tag,
  output logic                o_fill,
  output logic [IDX_BITS-1:0] o_fill_idx,
  output logic [TAG_BITS-1:0] o_fill_tag
);

  typedef struct packed {
    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
  } tag_entry_t;

  tag_entry_t [MEM_TAGS-1:0] entries;
  logic [MEM_TAGS-1:0]       pending;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      entries <= '0;
      pending <= '0;
    end else begin
      if (i_ret_tag != 4'h0) begin
        pending[i_ret_tag] <= 1'b0;
      end
      // A tag reused in its own return cycle is outstanding again.
      if (i_accept) begin
        entries[i_resp_tag].idx <= i_accept_idx;
        entries[i_resp_tag].tag <= i_accept_tag;
        pending[i_resp_tag]     <= 1'b1;
      end
    end
  end

  assign o_fill     = (i_ret_tag != 4'h0) && pending[i_ret_tag];
  assign o_fill_idx = entries[i_ret_tag].idx;
  assign o_fill_tag = entries[i_ret_tag].tag;

  // Memory only returns tags it accepted earlier and has not yet returned.
  a_ret_outstanding: assert property (
    @(posedge i_clock) disable iff (i_reset)
    (i_ret_tag != 4'h0) |-> pending[i_ret_tag]
  ) else $error("mem_tag_table: return of tag %0d not outstanding", i_ret_tag);

endmodule

//--- verilog/icache_array.sv
`timescale 1ns/1ps

module icache_array #(
  parameter  int NUM_LINES = 32,
  parameter  int ADDR_BITS = 16,
  localparam int IDX_BITS  = $clog2(NUM_LINES),
  localparam int TAG_BITS  = ADDR_BITS - 3 - IDX_BITS
) (
  input  logic                i_clock,
  input  logic                i_reset,
  input  logic [63:0]         i_fetch_addr,
  input  logic                i_in_window,
  input  logic                i_fill,
  input  logic [IDX_BITS-1:0] i_fill_idx,
  input  logic [TAG_BITS-1:0] i_fill_tag,
  input  logic [63:0]         i_fill_data,
  input  logic [IDX_BITS-1:0] i_tail_idx,
  output logic                o_hit,
  output logic [63:0]         o_hit_data,
  output logic                o_tag_match,
  output logic [TAG_BITS-1:0] o_tail_tag
);

  typedef struct packed {
    logic                valid;
    logic [TAG_BITS-1:0] tag;
  } line_meta_t;

  line_meta_t [NUM_LINES-1:0] meta;
  line_meta_t [NUM_LINES-1:0] next_meta;
  logic [63:0]                data_mem [NUM_LINES];

  logic [IDX_BITS-1:0] idx;
  logic [TAG_BITS-1:0] tag;
  logic                match;
  logic [TAG_BITS-1:0] fill_line_tag;
  logic                fill_ok;

  // --------------------------------------------------
  // Lookup
  // --------------------------------------------------

  assign idx   = i_fetch_addr[IDX_BITS+2:3];
  assign tag   = i_fetch_addr[ADDR_BITS-1:IDX_BITS+3];
  assign match = (meta[idx].tag == tag);

  assign o_tag_match = match;
  assign o_hit       = meta[idx].valid && match;
  assign o_hit_data  = data_mem[idx];
  assign o_tail_tag  = meta[i_tail_idx].tag;

  // --------------------------------------------------
  // Re-tag and fill
  // --------------------------------------------------

  // The fill is checked against the tag the line holds after this
  // cycle's re-tag, so a fill racing a re-tag of its own line is dropped.
  assign fill_line_tag = (i_fill_idx == idx) ? tag : meta[i_fill_idx].tag;
  assign fill_ok       = i_fill && (i_fill_tag == fill_line_tag);

  always_comb begin
    next_meta          = meta;
    next_meta[idx].tag = tag;
    // Re-tagging a line in the window, or one that still holds data,
    // drops its contents.
    if (!match && (i_in_window || meta[idx].valid)) begin
      next_meta[idx].valid = 1'b0;
    end
    if (fill_ok) begin
      next_meta[i_fill_idx].valid = 1'b1;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      meta <= '0;
    end else begin
      meta <= next_meta;
    end
  end

  always_ff @(posedge i_clock) begin
    if (fill_ok) begin
      data_mem[i_fill_idx] <= i_fill_data;
    end
  end

  a_fill_idx_known: assert property (
    @(posedge i_clock) disable iff (i_reset)
    i_fill |-> !$isunknown(i_fill_idx)
  ) else $error("icache_array: fill index unknown");

endmodule

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import icache_pkg::*; (
  input  logic        i_clock,
  input  logic        i_reset,
  input  logic        i_redirect,
  input  logic [63:0] i_redirect_pc,
  input  logic        i_stall,
  input  logic        i_hit,
  input  logic [63:0] i_hit_data,
  output logic [63:0] o_fetch_addr,
  output fetch_out_t  o_fetch,
  output logic        o_running
);

  fetch_state_e state;
  logic [63:0]  pc;
  logic         out_valid;
  logic [63:0]  out_pc;
  logic [63:0]  out_inst;
  logic         take;

  // A word is taken on a hit unless the core stalls or redirects.
  assign take = (state == FETCH_RUN) && i_hit && !i_stall && !i_redirect;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      state     <= FETCH_IDLE;
      pc        <= 64'h0;
      out_valid <= 1'b0;
    end else begin
      state     <= FETCH_RUN;
      out_valid <= take;
      if (i_redirect) begin
        pc <= i_redirect_pc;
      end else if (take) begin
        pc <= pc + 64'd8;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (take) begin
      out_pc   <= pc;
      out_inst <= i_hit_data;
    end
  end

  always_comb begin
    o_fetch.valid = out_valid;
    o_fetch.pc    = out_pc;
    o_fetch.inst  = out_inst;
  end

  assign o_fetch_addr = pc;
  assign o_running    = (state == FETCH_RUN);

  // Delivered words stay on 8-byte boundaries across redirects.
  a_pc_aligned: assert property (
    @(posedge i_clock) disable iff (i_reset)
    o_fetch.valid |-> (o_fetch.pc[2:0] == 3'b000)
  ) else $error("fetch_stage: unaligned pc %h delivered", o_fetch.pc);

endmodule

//--- verilog/icache_pkg.sv
package icache_pkg;

  // Slot 0 of the memory tag space means "no tag".
  localparam int MEM_TAGS = 16;

  // --------------------------------------------------
  // Enumerations
  // --------------------------------------------------

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } mem_command_e;

  typedef enum logic {
    FETCH_IDLE = 1'b0,
    FETCH_RUN  = 1'b1
  } fetch_state_e;

  // --------------------------------------------------
  // Bus and fetch structures
  // --------------------------------------------------

  typedef struct packed {
    mem_command_e command;
    logic [63:0]  addr;
  } mem_req_t;

  // A nonzero response accepts the request under that tag.
  // A nonzero tag marks the data as the return for that tag.
  typedef struct packed {
    logic [3:0]  response;
    logic [63:0] data;
    logic [3:0]  tag;
  } mem_resp_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] pc;
    logic [63:0] inst;
  } fetch_out_t;

endpackage
